//--- ramIf_defs.svh
// Single 16-bit chip, fixed 4-word burst and 4-word config table; widths are not meant to change
`ifndef RAM_IF_DEFS_SVH
`define RAM_IF_DEFS_SVH

// RAM data bus
`define RAM_DQ_WIDTH 16

// Data words per test burst
`define RAM_BURST_LEN 4

// Divided ticks with clock low and bus released before the first read strobe
`define RAM_RD_WAIT 5

// Command words, first word of every data transaction
`define RAM_CMD_WRITE 16'h00A5
`define RAM_CMD_READ 16'h005A

// Setup table sent once after reset, one word per chip-select frame
`define RAM_CFG_WORDS 4
`define RAM_CFG_WORD0 16'hC001
`define RAM_CFG_WORD1 16'hC102
`define RAM_CFG_WORD2 16'hC210
`define RAM_CFG_WORD3 16'hC300

`endif

//--- ramIfPkg.sv
// Shared bus, test and control types; errCount is 8 bits, so bursts stay below 256 words
`include "ramIf_defs.svh"

package ramIfPkg;

	// One bus source's view of the RAM pins
	typedef struct packed {
		logic [`RAM_DQ_WIDTH-1:0] dq;
		logic clk;
		// Chip select, active low
		logic cs;
		// High while the controller drives dq
		logic oe;
	} ramBusT;

	// Bus value with no transaction in flight
	localparam ramBusT busIdle = '{dq: '0, clk: 1'b0, cs: 1'b1, oe: 1'b1};

	typedef struct packed {
		logic [15:0] baseAddr;
	} ramTestReqT;

	typedef struct packed {
		logic done;
		logic pass;
		logic [7:0] errCount;
	} ramTestResT;

	typedef enum logic [1:0] {
		ctrlIdle,
		ctrlConfig,
		ctrlReady,
		ctrlTest
	} ramCtrlStateT;

endpackage

//--- ramPortUnit.sv
// Only one of cfgEn and testEn may be high; both high or both low parks the bus idle
`timescale 1ns/1ps
`include "ramIf_defs.svh"

module ramPortUnit import ramIfPkg::*;
(
	input  logic                     iCLK,
	input  logic                     reset,
	input  ramBusT                   cfgBus,
	input  ramBusT                   testBus,
	input  logic                     cfgEn,
	input  logic                     testEn,
	input  logic [7:0]               memClkDiv,
	input  logic [`RAM_DQ_WIDTH-1:0] ramDqIn,
	output logic [`RAM_DQ_WIDTH-1:0] ramDqOut,
	output logic [1:0]               ramDqOe,
	output logic [1:0]               ramClk,
	output logic [1:0]               ramCe,
	output logic [`RAM_DQ_WIDTH-1:0] ramRd,
	output logic                     ramRe
);

	ramBusT nextBus;
	ramBusT pinBus;
	logic [7:0] divCnt;
	logic [3:0] waitCnt;
	logic divTick;
	logic readLow;

	// Source select
	always_comb
	begin
		case ({testEn, cfgEn})
			2'b01:
			begin
				nextBus = cfgBus;
				// Setup words are always writes
				nextBus.oe = 1'b1;
			end
			2'b10:
				nextBus = testBus;
			default:
				nextBus = busIdle;
		endcase
	end

	assign divTick = (divCnt >= memClkDiv);
	// RAM owns the bus and its clock is low
	assign readLow = !pinBus.oe && !pinBus.clk;

	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			pinBus <= busIdle;
			divCnt <= 8'd0;
			waitCnt <= 4'd0;
			ramRe <= 1'b0;
		end
		else
		begin
			pinBus <= nextBus;
			// Divider only runs inside a chip-select frame
			if (pinBus.cs || divTick)
				divCnt <= 8'd0;
			else
				divCnt <= divCnt + 8'd1;
			if (pinBus.oe)
				waitCnt <= 4'd0;
			else if (readLow && divTick && (waitCnt != 4'(`RAM_RD_WAIT)))
				waitCnt <= waitCnt + 4'd1;
			ramRe <= readLow && divTick && (waitCnt == 4'(`RAM_RD_WAIT));
		end
	end

	// Read data follows the bus while the RAM clock is low
	always_ff @(posedge iCLK)
	begin
		if (!pinBus.clk)
			ramRd <= ramDqIn;
	end

	assign ramDqOut = pinBus.dq;
	// Both chip copies see the same pins
	assign ramDqOe = {2{pinBus.oe}};
	assign ramClk = {2{pinBus.clk}};
	assign ramCe = {2{pinBus.cs}};

endmodule

//--- ramCfgSeq.sv
// Runs once per start pulse; a start while the table is in flight is ignored
`timescale 1ns/1ps
`include "ramIf_defs.svh"

module ramCfgSeq import ramIfPkg::*;
(
	input  logic   iCLK,
	input  logic   reset,
	input  logic   start,
	input  logic   stepTick,
	output ramBusT cfgBus,
	output logic   cfgDone
);

	localparam int idxW = $clog2(`RAM_CFG_WORDS);
	localparam logic [idxW-1:0] lastIdx = idxW'(`RAM_CFG_WORDS - 1);
	localparam logic [`RAM_DQ_WIDTH-1:0] cfgTable [`RAM_CFG_WORDS] = '{
		`RAM_CFG_WORD0, `RAM_CFG_WORD1, `RAM_CFG_WORD2, `RAM_CFG_WORD3
	};

	typedef enum logic [2:0] {sIdle, sSetup, sHigh, sLow, sRelease} cfgStateT;

	cfgStateT cfgState;
	logic [idxW-1:0] wordIdx;

	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			cfgState <= sIdle;
			cfgBus <= busIdle;
			wordIdx <= '0;
			cfgDone <= 1'b0;
		end
		else
		begin
			cfgDone <= 1'b0;
			case (cfgState)
				sIdle:
					if (start)
					begin
						wordIdx <= '0;
						cfgState <= sSetup;
					end
				// Word on dq with cs low and clock low
				sSetup:
					if (stepTick)
					begin
						cfgBus.cs <= 1'b0;
						cfgBus.clk <= 1'b0;
						cfgBus.dq <= cfgTable[wordIdx];
						cfgState <= sHigh;
					end
				sHigh:
					if (stepTick)
					begin
						cfgBus.clk <= 1'b1;
						cfgState <= sLow;
					end
				sLow:
					if (stepTick)
					begin
						cfgBus.clk <= 1'b0;
						cfgState <= sRelease;
					end
				// One tick of cs high closes each word's frame
				sRelease:
					if (stepTick)
					begin
						cfgBus.cs <= 1'b1;
						if (wordIdx == lastIdx)
						begin
							cfgDone <= 1'b1;
							cfgState <= sIdle;
						end
						else
						begin
							wordIdx <= wordIdx + 1'b1;
							cfgState <= sSetup;
						end
					end
				default:
					cfgState <= sIdle;
			endcase
		end
	end

endmodule

//--- ramTestEngine.sv
// Pattern word k is baseAddr + k*0x0101 mod 2^16; the burst must fit below address 0x10000
`timescale 1ns/1ps
`include "ramIf_defs.svh"

module ramTestEngine import ramIfPkg::*;
(
	input  logic                     iCLK,
	input  logic                     reset,
	input  logic                     start,
	input  logic                     stepTick,
	input  ramTestReqT               req,
	input  logic [`RAM_DQ_WIDTH-1:0] ramRd,
	input  logic                     ramRe,
	output ramBusT                   testBus,
	output ramTestResT               result
);

	typedef enum logic [3:0] {
		sIdle, sSetup, sHigh, sLow, sRelease, sTurn, sRdHigh, sRdLow, sSettle, sWait
	} engStateT;

	engStateT engState;
	logic reading;
	logic [7:0] wordIdx;
	logic [15:0] baseAddr;
	logic [`RAM_DQ_WIDTH-1:0] txWord;

	function automatic logic [15:0] patternWord(input logic [15:0] base, input logic [7:0] k);
		patternWord = base + ({8'd0, k} * 16'h0101);
	endfunction

	// Command, then address, then write data
	always_comb
	begin
		if (wordIdx == 8'd0)
			txWord = reading ? `RAM_CMD_READ : `RAM_CMD_WRITE;
		else if (wordIdx == 8'd1)
			txWord = baseAddr;
		else
			txWord = patternWord(baseAddr, wordIdx - 8'd2);
	end

	always_ff @(posedge iCLK)
	begin
		if (engState == sIdle && start)
			baseAddr <= req.baseAddr;
	end

	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			engState <= sIdle;
			testBus <= busIdle;
			result <= '0;
			reading <= 1'b0;
			wordIdx <= 8'd0;
		end
		else
		begin
			result.done <= 1'b0;
			case (engState)
				sIdle:
					if (start)
					begin
						reading <= 1'b0;
						wordIdx <= 8'd0;
						result.pass <= 1'b0;
						result.errCount <= 8'd0;
						engState <= sSetup;
					end
				sSetup:
					if (stepTick)
					begin
						testBus.cs <= 1'b0;
						testBus.clk <= 1'b0;
						testBus.dq <= txWord;
						engState <= sHigh;
					end
				sHigh:
					if (stepTick)
					begin
						testBus.clk <= 1'b1;
						engState <= sLow;
					end
				sLow:
					if (stepTick)
					begin
						testBus.clk <= 1'b0;
						if (reading && wordIdx == 8'd1)
						begin
							wordIdx <= 8'd0;
							engState <= sTurn;
						end
						else if (!reading && wordIdx == 8'(`RAM_BURST_LEN + 1))
							engState <= sRelease;
						else
						begin
							wordIdx <= wordIdx + 8'd1;
							engState <= sSetup;
						end
					end
				sRelease:
					if (stepTick)
					begin
						testBus.cs <= 1'b1;
						testBus.oe <= 1'b1;
						if (reading)
						begin
							result.done <= 1'b1;
							result.pass <= (result.errCount == 8'd0);
							engState <= sIdle;
						end
						else
						begin
							reading <= 1'b1;
							wordIdx <= 8'd0;
							engState <= sSetup;
						end
					end
				// Hand the bus to the RAM
				sTurn:
					if (stepTick)
					begin
						testBus.oe <= 1'b0;
						engState <= sRdHigh;
					end
				sRdHigh:
					if (stepTick)
					begin
						testBus.clk <= 1'b1;
						engState <= sRdLow;
					end
				sRdLow:
					if (stepTick)
					begin
						testBus.clk <= 1'b0;
						engState <= sSettle;
					end
				// Skips a strobe issued before the port saw the high phase
				sSettle:
					engState <= sWait;
				sWait:
					if (ramRe)
					begin
						if (ramRd != patternWord(baseAddr, wordIdx))
							result.errCount <= result.errCount + 8'd1;
						if (wordIdx == 8'(`RAM_BURST_LEN - 1))
							engState <= sRelease;
						else
						begin
							wordIdx <= wordIdx + 8'd1;
							engState <= sRdHigh;
						end
					end
				default:
					engState <= sIdle;
			endcase
		end
	end

endmodule

//--- ramIfCtrl.sv
// Config starts by itself after reset; testStart counts only in the ready state
`timescale 1ns/1ps
`include "ramIf_defs.svh"

module ramIfCtrl import ramIfPkg::*;
(
	input  logic         iCLK,
	input  logic         reset,
	input  logic [7:0]   memClkDiv,
	input  logic         testStart,
	input  ramTestReqT   testReq,
	input  logic         cfgDone,
	input  ramTestResT   engineRes,
	output logic         stepTick,
	output logic         cfgStart,
	output logic         cfgEn,
	output logic         testEn,
	output logic         engineStart,
	output ramTestReqT   engineReq,
	output ramCtrlStateT state,
	output logic         busy,
	output logic         testDone,
	output logic         testPass,
	output logic [7:0]   errCount
);

	logic [7:0] tickCnt;

	// Pacing tick, once every memClkDiv+1 cycles
	assign stepTick = (tickCnt >= memClkDiv);

	always_ff @(posedge iCLK)
	begin
		if (reset || stepTick)
			tickCnt <= 8'd0;
		else
			tickCnt <= tickCnt + 8'd1;
	end

	// Bus goes only to the source of the active phase
	assign cfgEn = (state == ctrlConfig);
	assign testEn = (state == ctrlTest);
	assign busy = (state != ctrlReady);

	always_ff @(posedge iCLK)
	begin
		if (state == ctrlReady && testStart)
			engineReq <= testReq;
	end

	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			state <= ctrlIdle;
			cfgStart <= 1'b0;
			engineStart <= 1'b0;
			testDone <= 1'b0;
			testPass <= 1'b0;
			errCount <= 8'd0;
		end
		else
		begin
			cfgStart <= 1'b0;
			engineStart <= 1'b0;
			testDone <= 1'b0;
			case (state)
				ctrlIdle:
				begin
					cfgStart <= 1'b1;
					state <= ctrlConfig;
				end
				ctrlConfig:
					if (cfgDone)
						state <= ctrlReady;
				ctrlReady:
					if (testStart)
					begin
						engineStart <= 1'b1;
						// Previous result is dropped once a new test is under way
						testPass <= 1'b0;
						errCount <= 8'd0;
						state <= ctrlTest;
					end
				ctrlTest:
					if (engineRes.done)
					begin
						testDone <= 1'b1;
						testPass <= engineRes.pass;
						errCount <= engineRes.errCount;
						state <= ctrlReady;
					end
				default:
					state <= ctrlIdle;
			endcase
		end
	end

endmodule

//--- ramIfTop.sv
// RAM pins are split into dq out, dq in and a per-copy output enable; the tristate buffer is outside
`timescale 1ns/1ps
`include "ramIf_defs.svh"

module ramIfTop import ramIfPkg::*;
(
	input  logic                     iCLK,
	input  logic                     reset,
	input  logic [7:0]               memClkDiv,
	input  logic                     testStart,
	input  ramTestReqT               testReq,
	input  logic [`RAM_DQ_WIDTH-1:0] ramDqIn,
	output logic [`RAM_DQ_WIDTH-1:0] ramDqOut,
	output logic [1:0]               ramDqOe,
	output logic [1:0]               ramClk,
	output logic [1:0]               ramCe,
	output ramCtrlStateT             state,
	output logic                     busy,
	output logic                     testDone,
	output logic                     testPass,
	output logic [7:0]               errCount
);

	ramBusT cfgBus;
	ramBusT testBus;
	ramTestReqT engineReq;
	ramTestResT engineRes;
	logic stepTick;
	logic cfgStart;
	logic cfgDone;
	logic cfgEn;
	logic testEn;
	logic engineStart;
	logic [`RAM_DQ_WIDTH-1:0] ramRd;
	logic ramRe;

	ramIfCtrl ctrl_i (
		.iCLK(iCLK), .reset(reset), .memClkDiv(memClkDiv),
		.testStart(testStart), .testReq(testReq),
		.cfgDone(cfgDone), .engineRes(engineRes),
		.stepTick(stepTick), .cfgStart(cfgStart), .cfgEn(cfgEn), .testEn(testEn),
		.engineStart(engineStart), .engineReq(engineReq),
		.state(state), .busy(busy), .testDone(testDone),
		.testPass(testPass), .errCount(errCount)
	);

	ramCfgSeq cfgSeq_i (
		.iCLK(iCLK), .reset(reset), .start(cfgStart), .stepTick(stepTick),
		.cfgBus(cfgBus), .cfgDone(cfgDone)
	);

	ramTestEngine engine_i (
		.iCLK(iCLK), .reset(reset), .start(engineStart), .stepTick(stepTick),
		.req(engineReq), .ramRd(ramRd), .ramRe(ramRe),
		.testBus(testBus), .result(engineRes)
	);

	ramPortUnit port_i (
		.iCLK(iCLK), .reset(reset), .cfgBus(cfgBus), .testBus(testBus),
		.cfgEn(cfgEn), .testEn(testEn), .memClkDiv(memClkDiv),
		.ramDqIn(ramDqIn), .ramDqOut(ramDqOut), .ramDqOe(ramDqOe),
		.ramClk(ramClk), .ramCe(ramCe), .ramRd(ramRd), .ramRe(ramRe)
	);

endmodule

//--- tbRamModel.sv
// Burst RAM on one pin copy; 64K words, fill is the inverted address, stuck bit hits reads only
`timescale 1ns/1ps
`include "ramIf_defs.svh"

module tbRamModel #(
	parameter int stuckBit = 0
)
(
	input  logic                     ramClk,
	input  logic                     ramCe,
	input  logic                     ramOe,
	input  logic [`RAM_DQ_WIDTH-1:0] dqIn,
	input  logic                     stuckEn,
	output logic [`RAM_DQ_WIDTH-1:0] dqOut
);

	logic [`RAM_DQ_WIDTH-1:0] mem [0:65535];
	logic [`RAM_DQ_WIDTH-1:0] cfgCap [0:15];
	int cfgCount;
	int wordCnt;
	logic [`RAM_DQ_WIDTH-1:0] cmd;
	logic [15:0] addr;

	initial
	begin
		for (int a = 0; a < 65536; a++)
			mem[a] = ~16'(a);
		cfgCount = 0;
		wordCnt = 0;
		cmd = '0;
		addr = '0;
		dqOut = '0;
	end

	// Word decode on each rising RAM clock inside a frame
	always @(posedge ramClk or posedge ramCe)
	begin
		if (ramCe)
			wordCnt = 0;
		else
		begin
			if (wordCnt == 0)
			begin
				cmd = dqIn;
				// Any first word that is no command is a setup word
				if (dqIn != `RAM_CMD_WRITE && dqIn != `RAM_CMD_READ && cfgCount < 16)
				begin
					cfgCap[cfgCount] = dqIn;
					cfgCount++;
				end
			end
			else if (wordCnt == 1)
				addr = dqIn;
			else if (cmd == `RAM_CMD_WRITE && ramOe)
				mem[16'(addr + wordCnt - 2)] = dqIn;
			else if (cmd == `RAM_CMD_READ && !ramOe)
			begin
				dqOut = mem[16'(addr + wordCnt - 2)];
				if (stuckEn)
					dqOut[stuckBit] = 1'b1;
			end
			wordCnt++;
		end
	end

endmodule

//--- tbRamIfTop.sv
// Model sits on pin copy 0, copy 1 is only compared; bases stay at or below 0xFFFC
`timescale 1ns/1ps
`include "ramIf_defs.svh"

module tbRamIfTop import ramIfPkg::*;
();

	localparam int stuckBitTb = 0;
	localparam int readyTimeout = 5000;
	localparam int doneTimeout = 5000;
	localparam logic [15:0] cfgTableExp [`RAM_CFG_WORDS] = '{
		`RAM_CFG_WORD0, `RAM_CFG_WORD1, `RAM_CFG_WORD2, `RAM_CFG_WORD3
	};

	logic iCLK;
	logic reset;
	logic [7:0] memClkDiv;
	logic testStart;
	ramTestReqT testReq;
	logic [`RAM_DQ_WIDTH-1:0] ramDqIn;
	logic [`RAM_DQ_WIDTH-1:0] ramDqOut;
	logic [1:0] ramDqOe;
	logic [1:0] ramClk;
	logic [1:0] ramCe;
	ramCtrlStateT ctrlState;
	logic busy;
	logic testDone;
	logic testPass;
	logic [7:0] errCount;
	logic stuckEn;

	int valueErrors = 0;
	int timeoutErrors = 0;
	int pinErrors = 0;
	int doneCount = 0;
	integer seed;

	ramIfTop dut_i (
		.iCLK(iCLK), .reset(reset), .memClkDiv(memClkDiv),
		.testStart(testStart), .testReq(testReq),
		.ramDqIn(ramDqIn), .ramDqOut(ramDqOut), .ramDqOe(ramDqOe),
		.ramClk(ramClk), .ramCe(ramCe), .state(ctrlState), .busy(busy),
		.testDone(testDone), .testPass(testPass), .errCount(errCount)
	);

	tbRamModel #(.stuckBit(stuckBitTb)) model_i (
		.ramClk(ramClk[0]), .ramCe(ramCe[0]), .ramOe(ramDqOe[0]), .dqIn(ramDqOut),
		.stuckEn(stuckEn), .dqOut(ramDqIn)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #2 iCLK = ~iCLK;
	end

	always @(negedge iCLK)
	begin
		if (!reset && testDone)
			doneCount++;
	end

	// Both chip copies equal, and a deselected chip never has the bus released
	always @(negedge iCLK)
	begin
		if (!reset)
		begin
			if (ramCe[0] !== ramCe[1] || ramClk[0] !== ramClk[1] || ramDqOe[0] !== ramDqOe[1])
			begin
				$display("Pin copies differ at %0t: ce %b clk %b oe %b", $time, ramCe, ramClk,
					ramDqOe);
				pinErrors++;
			end
			if (ramCe[0] && !ramDqOe[0])
			begin
				$display("Bus released while the chip is deselected at %0t", $time);
				pinErrors++;
			end
		end
	end

	// Word k of a burst is base + k*0x0101
	function automatic logic [15:0] patternOf(input logic [15:0] base, input int k);
		logic [7:0] kb;
		kb = 8'(k);
		return base + {kb, kb};
	endfunction

	task automatic waitReady(input string name);
		int cycles;
		cycles = 0;
		while (ctrlState != ctrlReady && cycles < readyTimeout)
		begin
			@(negedge iCLK);
			cycles++;
		end
		if (ctrlState != ctrlReady)
		begin
			$display("Timeout in %s: controller never reached the ready state", name);
			timeoutErrors++;
		end
	endtask

	task automatic waitDone(input string name, input int startDone);
		int cycles;
		cycles = 0;
		while (doneCount == startDone && cycles < doneTimeout)
		begin
			@(negedge iCLK);
			cycles++;
		end
		if (doneCount == startDone)
		begin
			$display("Timeout in %s: no testDone within %0d cycles", name, doneTimeout);
			timeoutErrors++;
		end
	endtask

	task automatic launchTest(input logic [15:0] base);
		@(negedge iCLK);
		testReq.baseAddr = base;
		testStart = 1'b1;
		@(negedge iCLK);
		testStart = 1'b0;
	endtask

	task automatic checkResult(input string name, input logic [15:0] base, input int expErr,
		input logic expPass);
		logic [15:0] addr;
		if (errCount !== 8'(expErr))
		begin
			$display("[FAIL] %s errCount: expected %0d, actual %0d", name, expErr, errCount);
			valueErrors++;
		end
		if (testPass !== expPass)
		begin
			$display("[FAIL] %s testPass: expected %b, actual %b", name, expPass, testPass);
			valueErrors++;
		end
		for (int k = 0; k < `RAM_BURST_LEN; k++)
		begin
			addr = base + 16'(k);
			if (model_i.mem[addr] !== patternOf(base, k))
			begin
				$display("[FAIL] %s mem[%h]: expected %h, actual %h", name, addr,
					patternOf(base, k), model_i.mem[addr]);
				valueErrors++;
			end
		end
	endtask

	task automatic burstAndCheck(input string name, input logic [15:0] base, input int expErr,
		input logic expPass);
		int startDone;
		waitReady(name);
		startDone = doneCount;
		launchTest(base);
		waitDone(name, startDone);
		checkResult(name, base, expErr, expPass);
	endtask

	task automatic resetAndConfig();
		logic [7:0] gotPins;
		gotPins = {ramCe, ramDqOe, ramClk, testDone, busy};
		// cs high, oe high, clock low, no done, busy
		if (gotPins !== 8'b1111_0001)
		begin
			$display("[FAIL] resetAndConfig pins: expected %b, actual %b", 8'b1111_0001, gotPins);
			valueErrors++;
		end
		// Parked bus carries zero data
		if (ramDqOut !== 16'h0000)
		begin
			$display("[FAIL] resetAndConfig dq: expected %h, actual %h", 16'h0000, ramDqOut);
			valueErrors++;
		end
		waitReady("resetAndConfig");
		if (model_i.cfgCount != `RAM_CFG_WORDS)
		begin
			$display("[FAIL] resetAndConfig word count: expected %0d, actual %0d",
				`RAM_CFG_WORDS, model_i.cfgCount);
			valueErrors++;
		end
		for (int i = 0; i < `RAM_CFG_WORDS; i++)
		begin
			if (model_i.cfgCap[i] !== cfgTableExp[i])
			begin
				$display("[FAIL] resetAndConfig word %0d: expected %h, actual %h", i,
					cfgTableExp[i], model_i.cfgCap[i]);
				valueErrors++;
			end
		end
	endtask

	task automatic basicBurst();
		memClkDiv = 8'd0;
		burstAndCheck("basicBurst", 16'h0000, 0, 1'b1);
	endtask

	task automatic randomBursts();
		logic [31:0] rnd;
		logic [15:0] base;
		memClkDiv = 8'd3;
		for (int i = 0; i < 3; i++)
		begin
			rnd = $random(seed);
			base = rnd[15:0];
			// Whole burst below 0x10000
			if (base > 16'hFFFC)
				base = 16'hFFFC;
			burstAndCheck($sformatf("randomBurst%0d", i), base, 0, 1'b1);
		end
	endtask

	task automatic stuckBitFault();
		logic [15:0] base;
		logic [15:0] word;
		int expErr;
		base = 16'h1000;
		expErr = 0;
		for (int k = 0; k < `RAM_BURST_LEN; k++)
		begin
			word = patternOf(base, k);
			if (!word[stuckBitTb])
				expErr++;
		end
		memClkDiv = 8'd1;
		stuckEn = 1'b1;
		burstAndCheck("stuckBitFault", base, expErr, 1'b0);
		stuckEn = 1'b0;
	endtask

	task automatic startWhileBusy();
		logic [15:0] firstBase;
		logic [15:0] secondBase;
		int startDone;
		firstBase = 16'h2468;
		secondBase = 16'h8000;
		memClkDiv = 8'd3;
		// Words that no burst to the second base could leave behind
		for (int k = 0; k < `RAM_BURST_LEN; k++)
			model_i.mem[secondBase + 16'(k)] = ~patternOf(secondBase, k);
		waitReady("startWhileBusy");
		startDone = doneCount;
		launchTest(firstBase);
		repeat (20) @(negedge iCLK);
		if (ctrlState != ctrlTest)
		begin
			$display("[FAIL] startWhileBusy state: expected %0d, actual %0d", ctrlTest, ctrlState);
			valueErrors++;
		end
		launchTest(secondBase);
		waitDone("startWhileBusy", startDone);
		// Long enough for a stray second test to finish
		repeat (1000) @(negedge iCLK);
		if (doneCount != startDone + 1)
		begin
			$display("[FAIL] startWhileBusy done pulses: expected %0d, actual %0d", 1,
				doneCount - startDone);
			valueErrors++;
		end
		checkResult("startWhileBusy", firstBase, 0, 1'b1);
		for (int k = 0; k < `RAM_BURST_LEN; k++)
		begin
			if (model_i.mem[secondBase + 16'(k)] !== ~patternOf(secondBase, k))
			begin
				$display("[FAIL] startWhileBusy mem[%h]: expected %h, actual %h",
					secondBase + 16'(k), ~patternOf(secondBase, k),
					model_i.mem[secondBase + 16'(k)]);
				valueErrors++;
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		memClkDiv = 8'd0;
		testStart = 1'b0;
		testReq = '0;
		stuckEn = 1'b0;
		seed = 32'he2ae_897b;
		repeat (10) @(posedge iCLK);
		@(negedge iCLK);
		reset = 1'b0;
		resetAndConfig();
		basicBurst();
		randomBursts();
		stuckBitFault();
		startWhileBusy();
		$display("Errors: %0d value, %0d timeout, %0d pin", valueErrors, timeoutErrors,
			pinErrors);
		if (valueErrors + timeoutErrors + pinErrors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
ramIfPkg.sv
ramPortUnit.sv
ramCfgSeq.sv
ramTestEngine.sv
ramIfCtrl.sv
ramIfTop.sv
tbRamModel.sv
tbRamIfTop.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and returns a failing status on a failed run
cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing -Wno-fatal --top-module tbRamIfTop \
	--Mdir "$buildDir" -o tbRamIfTop -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/tbRamIfTop" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Test failed" "$logFile"; then
	exit 1
fi
if ! grep -q "Test completed successfully" "$logFile"; then
	echo "No result line found in $logFile"
	exit 1
fi
exit 0
